// ==== include/sdram_defs.svh ====
`ifndef SDRAM_DEFS_SVH
`define SDRAM_DEFS_SVH

// bus widths
`define SDRAM_DATA_WIDTH 32
`define SDRAM_ROW_WIDTH 11
`define SDRAM_COL_WIDTH 8
`define SDRAM_BANK_BITS 2

// burst length 1, cas latency 2, sequential
`define SDRAM_MODE_VALUE 'h20
`define SDRAM_CAS_LATENCY 2

// command spacing in clk cycles
`define SDRAM_TRCD 2
`define SDRAM_TRP 2
`define SDRAM_TRC 6
`define SDRAM_TWR_AP 4

`define SDRAM_INIT_WAIT 40
// kept short so refreshes show up in simulation
`define SDRAM_REFRESH_INTERVAL 200

`endif

// ==== source/sdram_pkg.sv ====
`default_nettype none

package sdram_pkg;

`include "sdram_defs.svh"

    typedef enum logic [2:0] {
        CMD_NOP,
        CMD_ACTIVATE,
        CMD_READ,
        CMD_WRITE,
        CMD_PRECHARGE_ALL,
        CMD_REFRESH,
        CMD_LOAD_MODE
    } sdram_cmd_t;

    // registered command bus as it leaves the chip
    typedef struct packed {
        logic                        ncs;
        logic                        nras;
        logic                        ncas;
        logic                        nwe;
        logic [`SDRAM_BANK_BITS-1:0] ba;
        logic [`SDRAM_ROW_WIDTH-1:0] address;
    } sdram_pins_t;

    typedef struct packed {
        logic [`SDRAM_BANK_BITS-1:0]    bank;
        logic [`SDRAM_ROW_WIDTH-1:0]    row;
        logic [`SDRAM_COL_WIDTH-1:0]    col;
        logic [`SDRAM_DATA_WIDTH-1:0]   wdata;
        logic [`SDRAM_DATA_WIDTH/8-1:0] nwr;
    } cpu_req_t;

    typedef enum logic [3:0] {
        ST_INIT_WAIT,
        ST_INIT_PRECHARGE,
        ST_INIT_REFRESH,
        ST_INIT_MODE,
        ST_IDLE,
        ST_REFRESH,
        ST_ACTIVATE_WAIT,
        ST_ACCESS,
        ST_READ_WAIT,
        ST_WRITE_RECOVER
    } seq_state_t;

endpackage

`default_nettype wire

// ==== source/sdram_timer.sv ====
`default_nettype none

`include "sdram_defs.svh"

module sdram_timer (
    input  wire       clk,
    input  wire       nreset,
    input  wire       timer_load,
    input  wire [7:0] timer_count,
    output logic      timer_done,
    input  wire       refresh_ack,
    output logic      refresh_due
);

    localparam int REF_W = $clog2(`SDRAM_REFRESH_INTERVAL);

    logic [7:0]       count;
    logic [REF_W-1:0] ref_count;

    // power-up delay runs straight out of reset
    always_ff @(posedge clk) begin
        if (!nreset) begin
            count <= 8'(`SDRAM_INIT_WAIT);
        end else if (timer_load) begin
            count <= timer_count;
        end else if (count != 8'd0) begin
            count <= count - 8'd1;
        end
    end

    assign timer_done = (count == 8'd0);

    always_ff @(posedge clk) begin
        if (!nreset) begin
            ref_count   <= '0;
            refresh_due <= 1'b0;
        end else begin
            if (refresh_ack) begin
                refresh_due <= 1'b0;
            end
            if (ref_count == REF_W'(`SDRAM_REFRESH_INTERVAL - 1)) begin
                ref_count   <= '0;
                refresh_due <= 1'b1;
            end else begin
                ref_count <= ref_count + 1'b1;
            end
        end
    end

    // the sequencer must let a gap run out before starting the next one
    assert property (@(posedge clk) disable iff (!nreset) timer_load |-> timer_done)
        else $error("timer reloaded while a command gap was still running");

endmodule

`default_nettype wire

// ==== source/sdram_sequencer.sv ====
`default_nettype none

`include "sdram_defs.svh"

module sdram_sequencer
    import sdram_pkg::*;
(
    input  wire        clk,
    input  wire        nreset,
    input  wire        cpu_req,
    input  wire        is_read,
    output logic       cpu_ack,
    output sdram_cmd_t cmd,
    output logic       timer_load,
    output logic [7:0] timer_count,
    input  wire        timer_done,
    input  wire        refresh_due,
    output logic       refresh_ack,
    output logic       read_issue,
    input  wire        data_ready
);

    // the timer counts down to zero, so each gap loads one less
    localparam logic [7:0] TRP_LOAD = 8'(`SDRAM_TRP - 1);
    localparam logic [7:0] TRC_LOAD = 8'(`SDRAM_TRC - 1);
    localparam logic [7:0] TWR_LOAD = 8'(`SDRAM_TWR_AP - 1);
    // ACCESS itself takes one of the tRCD cycles
    localparam logic [7:0] RCD_LOAD = 8'(`SDRAM_TRCD - 2);

    seq_state_t state;
    seq_state_t next_state;
    logic       init_ref_done;
    logic       write_ack;

    always_comb begin
        next_state  = state;
        cmd         = CMD_NOP;
        timer_load  = 1'b0;
        timer_count = '0;
        refresh_ack = 1'b0;
        read_issue  = 1'b0;
        case (state)
            ST_INIT_WAIT: begin
                if (timer_done) begin
                    cmd         = CMD_PRECHARGE_ALL;
                    timer_load  = 1'b1;
                    timer_count = TRP_LOAD;
                    next_state  = ST_INIT_PRECHARGE;
                end
            end
            ST_INIT_PRECHARGE: begin
                if (timer_done) begin
                    cmd         = CMD_REFRESH;
                    refresh_ack = 1'b1;
                    timer_load  = 1'b1;
                    timer_count = TRC_LOAD;
                    next_state  = ST_INIT_REFRESH;
                end
            end
            ST_INIT_REFRESH: begin
                if (timer_done && !init_ref_done) begin
                    cmd         = CMD_REFRESH;
                    refresh_ack = 1'b1;
                    timer_load  = 1'b1;
                    timer_count = TRC_LOAD;
                end else if (timer_done) begin
                    // mode register set time, same length as tRP here
                    cmd         = CMD_LOAD_MODE;
                    timer_load  = 1'b1;
                    timer_count = TRP_LOAD;
                    next_state  = ST_INIT_MODE;
                end
            end
            ST_INIT_MODE: begin
                if (timer_done) begin
                    next_state = ST_IDLE;
                end
            end
            ST_IDLE: begin
                // refresh wins over a waiting request
                if (timer_done && refresh_due) begin
                    cmd         = CMD_REFRESH;
                    refresh_ack = 1'b1;
                    timer_load  = 1'b1;
                    timer_count = TRC_LOAD;
                    next_state  = ST_REFRESH;
                end else if (timer_done && cpu_req && !cpu_ack) begin
                    cmd         = CMD_ACTIVATE;
                    timer_load  = 1'b1;
                    timer_count = RCD_LOAD;
                    next_state  = ST_ACTIVATE_WAIT;
                end
            end
            ST_REFRESH, ST_WRITE_RECOVER: begin
                if (timer_done) begin
                    next_state = ST_IDLE;
                end
            end
            ST_ACTIVATE_WAIT: begin
                if (timer_done) begin
                    next_state = ST_ACCESS;
                end
            end
            ST_ACCESS: begin
                if (is_read) begin
                    cmd        = CMD_READ;
                    read_issue = 1'b1;
                    next_state = ST_READ_WAIT;
                end else begin
                    cmd         = CMD_WRITE;
                    timer_load  = 1'b1;
                    timer_count = TWR_LOAD;
                    next_state  = ST_WRITE_RECOVER;
                end
            end
            ST_READ_WAIT: begin
                if (data_ready) begin
                    next_state = ST_IDLE;
                end
            end
            default: begin
                next_state = ST_INIT_WAIT;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!nreset) begin
            state         <= ST_INIT_WAIT;
            init_ref_done <= 1'b0;
            write_ack     <= 1'b0;
            cpu_ack       <= 1'b0;
        end else begin
            state     <= next_state;
            write_ack <= (state == ST_ACCESS) && !is_read;
            if (state == ST_INIT_REFRESH && timer_done) begin
                init_ref_done <= 1'b1;
            end
            // ack a write one cycle after the command so data is still held
            if (write_ack || data_ready) begin
                cpu_ack <= 1'b1;
            end else if (!cpu_req) begin
                cpu_ack <= 1'b0;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!nreset) $rose(cpu_ack) |-> $past(cpu_req))
        else $error("cpu_ack raised with no request pending");

    // read data must come back while the read is still outstanding
    assert property (@(posedge clk) disable iff (!nreset)
        data_ready |-> (state == ST_READ_WAIT))
        else $error("read data returned outside of a read access");

endmodule

`default_nettype wire

// ==== source/sdram_cmd_reg.sv ====
`default_nettype none

`include "sdram_defs.svh"

module sdram_cmd_reg
    import sdram_pkg::*;
(
    input  wire                            clk,
    input  wire                            nreset,
    input  wire sdram_cmd_t                cmd,
    input  wire cpu_req_t                  req,
    output sdram_pins_t                    pins,
    output logic [`SDRAM_DATA_WIDTH-1:0]   sdram_data_out,
    output logic [`SDRAM_DATA_WIDTH/8-1:0] sdram_dqm
);

    localparam int NUM_BYTES = `SDRAM_DATA_WIDTH / 8;
    // A10 selects auto-precharge and precharge-all
    localparam int AP_BIT = 10;

    sdram_pins_t                 next_pins;
    logic [`SDRAM_BANK_BITS-1:0] act_bank;
    logic                        is_read;

    assign is_read        = (req.nwr == {NUM_BYTES{1'b1}});
    assign sdram_data_out = req.wdata;
    // dqm high on a read would blank the returned data
    assign sdram_dqm      = is_read ? '0 : req.nwr;

    always_comb begin
        next_pins     = pins;
        next_pins.ncs = 1'b0;
        case (cmd)
            CMD_ACTIVATE: begin
                {next_pins.nras, next_pins.ncas, next_pins.nwe} = 3'b011;
                next_pins.ba      = req.bank;
                next_pins.address = req.row;
            end
            CMD_READ, CMD_WRITE: begin
                {next_pins.nras, next_pins.ncas} = 2'b10;
                next_pins.nwe                    = (cmd == CMD_READ);
                next_pins.ba                     = req.bank;
                next_pins.address                = '0;
                next_pins.address[`SDRAM_COL_WIDTH-1:0] = req.col;
                next_pins.address[AP_BIT]        = 1'b1;
            end
            CMD_PRECHARGE_ALL: begin
                {next_pins.nras, next_pins.ncas, next_pins.nwe} = 3'b010;
                next_pins.address[AP_BIT] = 1'b1;
            end
            CMD_REFRESH: begin
                {next_pins.nras, next_pins.ncas, next_pins.nwe} = 3'b001;
            end
            CMD_LOAD_MODE: begin
                {next_pins.nras, next_pins.ncas, next_pins.nwe} = 3'b000;
                next_pins.ba      = '0;
                next_pins.address = `SDRAM_ROW_WIDTH'(`SDRAM_MODE_VALUE);
            end
            default: begin
                // deselect
                next_pins.ncs = 1'b1;
                {next_pins.nras, next_pins.ncas, next_pins.nwe} = 3'b111;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!nreset) begin
            pins <= '{ncs: 1'b1, nras: 1'b1, ncas: 1'b1, nwe: 1'b1, ba: '0, address: '0};
        end else begin
            pins <= next_pins;
        end
    end

    always_ff @(posedge clk) begin
        if (cmd == CMD_ACTIVATE) begin
            act_bank <= req.bank;
        end
    end

    assert property (@(posedge clk) disable iff (!nreset)
        (cmd == CMD_READ || cmd == CMD_WRITE) |-> req.bank == act_bank)
        else $error("column command to a bank that was not activated");

endmodule

`default_nettype wire

// ==== source/sdram_read_capture.sv ====
`default_nettype none

`include "sdram_defs.svh"

module sdram_read_capture (
    input  wire                          clk,
    input  wire                          nreset,
    input  wire                          read_issue,
    input  wire [`SDRAM_DATA_WIDTH-1:0]  sdram_data_in,
    output logic [`SDRAM_DATA_WIDTH-1:0] cpu_data_out,
    output logic                         data_ready
);

    // one stage for the command register, then CAS latency
    localparam int DEPTH = `SDRAM_CAS_LATENCY + 1;

    logic [DEPTH-1:0] strobe;

    always_ff @(posedge clk) begin
        if (!nreset) begin
            strobe <= '0;
        end else begin
            strobe <= {strobe[DEPTH-2:0], read_issue};
        end
    end

    assign data_ready = strobe[DEPTH-1];

    always_ff @(posedge clk) begin
        if (data_ready) begin
            cpu_data_out <= sdram_data_in;
        end
    end

endmodule

`default_nettype wire

// ==== source/sdram_controller.sv ====
`default_nettype none

`include "sdram_defs.svh"

module sdram_controller
    import sdram_pkg::*;
(
    input  wire                            clk,
    input  wire                            nreset,
    input  wire [`SDRAM_BANK_BITS+`SDRAM_ROW_WIDTH+`SDRAM_COL_WIDTH-1:0] cpu_address,
    input  wire [`SDRAM_DATA_WIDTH-1:0]    cpu_data_in,
    output logic [`SDRAM_DATA_WIDTH-1:0]   cpu_data_out,
    input  wire                            cpu_req,
    input  wire [`SDRAM_DATA_WIDTH/8-1:0]  cpu_nwr,
    output logic                           cpu_ack,
    output logic                           sdram_clk,
    output logic [`SDRAM_ROW_WIDTH-1:0]    sdram_address,
    output logic [`SDRAM_BANK_BITS-1:0]    sdram_ba,
    output logic                           sdram_ncs,
    output logic                           sdram_nras,
    output logic                           sdram_ncas,
    output logic                           sdram_nwe,
    input  wire [`SDRAM_DATA_WIDTH-1:0]    sdram_data_in,
    output logic [`SDRAM_DATA_WIDTH-1:0]   sdram_data_out,
    output logic [`SDRAM_DATA_WIDTH/8-1:0] sdram_dqm
);

    localparam int COL_W = `SDRAM_COL_WIDTH;
    localparam int ROW_HI = `SDRAM_COL_WIDTH + `SDRAM_ROW_WIDTH;
    localparam int ADDR_W = ROW_HI + `SDRAM_BANK_BITS;

    cpu_req_t    req;
    sdram_pins_t pins;
    sdram_cmd_t  cmd;
    logic        is_read;
    logic        timer_load;
    logic [7:0]  timer_count;
    logic        timer_done;
    logic        refresh_due;
    logic        refresh_ack;
    logic        read_issue;
    logic        data_ready;

    // address is bank, row, column from the top down
    assign req = '{
        bank:  cpu_address[ADDR_W-1:ROW_HI],
        row:   cpu_address[ROW_HI-1:COL_W],
        col:   cpu_address[COL_W-1:0],
        wdata: cpu_data_in,
        nwr:   cpu_nwr
    };

    assign is_read   = &cpu_nwr;
    assign sdram_clk = ~clk;

    assign sdram_ncs     = pins.ncs;
    assign sdram_nras    = pins.nras;
    assign sdram_ncas    = pins.ncas;
    assign sdram_nwe     = pins.nwe;
    assign sdram_ba      = pins.ba;
    assign sdram_address = pins.address;

    sdram_timer i_timer (
        .clk         (clk),
        .nreset      (nreset),
        .timer_load  (timer_load),
        .timer_count (timer_count),
        .timer_done  (timer_done),
        .refresh_ack (refresh_ack),
        .refresh_due (refresh_due)
    );

    sdram_sequencer i_sequencer (
        .clk         (clk),
        .nreset      (nreset),
        .cpu_req     (cpu_req),
        .is_read     (is_read),
        .cpu_ack     (cpu_ack),
        .cmd         (cmd),
        .timer_load  (timer_load),
        .timer_count (timer_count),
        .timer_done  (timer_done),
        .refresh_due (refresh_due),
        .refresh_ack (refresh_ack),
        .read_issue  (read_issue),
        .data_ready  (data_ready)
    );

    sdram_cmd_reg i_cmd_reg (
        .clk            (clk),
        .nreset         (nreset),
        .cmd            (cmd),
        .req            (req),
        .pins           (pins),
        .sdram_data_out (sdram_data_out),
        .sdram_dqm      (sdram_dqm)
    );

    sdram_read_capture i_read_capture (
        .clk           (clk),
        .nreset        (nreset),
        .read_issue    (read_issue),
        .sdram_data_in (sdram_data_in),
        .cpu_data_out  (cpu_data_out),
        .data_ready    (data_ready)
    );

endmodule

`default_nettype wire

// ==== test/sdram_model.sv ====
`default_nettype none

`include "sdram_defs.svh"

module sdram_model (
    input  wire                            clk,
    input  wire [`SDRAM_ROW_WIDTH-1:0]     address,
    input  wire [`SDRAM_BANK_BITS-1:0]     ba,
    input  wire                            ncs,
    input  wire                            nras,
    input  wire                            ncas,
    input  wire                            nwe,
    input  wire [`SDRAM_DATA_WIDTH-1:0]    data_in,
    input  wire [`SDRAM_DATA_WIDTH/8-1:0]  dqm,
    output logic [`SDRAM_DATA_WIDTH-1:0]   data_out,
    output logic                           init_done,
    output logic [`SDRAM_ROW_WIDTH-1:0]    mode_value,
    output int                             refresh_count,
    output int                             access_count,
    output int                             violations
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_BANKS = 1 << `SDRAM_BANK_BITS;
    localparam int NBYTES = `SDRAM_DATA_WIDTH / 8;
    localparam int CL = `SDRAM_CAS_LATENCY;

    logic [`SDRAM_DATA_WIDTH-1:0] mem [int];
    logic [`SDRAM_ROW_WIDTH-1:0]  open_row [NUM_BANKS];
    bit                           bank_open [NUM_BANKS];
    int                           act_cycle [NUM_BANKS];
    logic [CL-1:0]                rd_valid = '0;
    logic [`SDRAM_DATA_WIDTH-1:0] rd_data [CL];
    logic [`SDRAM_ROW_WIDTH-1:0]  mode_reg = '0;
    bit                           precharged = 1'b0;
    bit                           inited = 1'b0;
    int                           cycle = 0;
    int                           busy_until = 0;
    int                           n_refresh = 0;
    int                           n_access = 0;
    int                           n_violation = 0;

    initial begin
        data_out = '0;
        init_done = 1'b0;
        mode_value = '0;
        refresh_count = 0;
        access_count = 0;
        violations = 0;
    end

    task automatic report_violation(input string msg);
        n_violation++;
        $display("protocol violation at %0t: %s", $time, msg);
    endtask

    // unwritten locations read back a value tied to the full address
    function automatic logic [`SDRAM_DATA_WIDTH-1:0] fill_word(input int key);
        return (32'(key) * 32'h9e3779b1) ^ 32'h5a5a5a5a;
    endfunction

    always @(posedge clk) begin
        int                           key;
        logic [`SDRAM_DATA_WIDTH-1:0] word;
        cycle++;
        data_out <= rd_valid[CL-1] ? rd_data[CL-1] : '0;
        for (int i = CL - 1; i > 0; i--) begin
            rd_valid[i] <= rd_valid[i-1];
            rd_data[i]  <= rd_data[i-1];
        end
        rd_valid[0] <= 1'b0;
        if (ncs === 1'b0 && {nras, ncas, nwe} !== 3'b111) begin
            if (cycle < busy_until) begin
                report_violation("command issued inside a tRP or tRC window");
            end
            key = int'({ba, open_row[ba], address[`SDRAM_COL_WIDTH-1:0]});
            case ({nras, ncas, nwe})
                3'b010: begin
                    if (!address[10]) begin
                        report_violation("single bank precharge was not expected");
                    end
                    for (int b = 0; b < NUM_BANKS; b++) begin
                        bank_open[b] = 1'b0;
                    end
                    precharged = 1'b1;
                    busy_until = cycle + `SDRAM_TRP;
                end
                3'b001: begin
                    for (int b = 0; b < NUM_BANKS; b++) begin
                        if (bank_open[b]) begin
                            report_violation("refresh while a bank is open");
                        end
                    end
                    n_refresh++;
                    busy_until = cycle + `SDRAM_TRC;
                end
                3'b000: begin
                    if (!precharged || n_refresh < 2) begin
                        report_violation("mode register loaded before precharge and two refreshes");
                    end
                    mode_reg = address;
                    inited = 1'b1;
                    busy_until = cycle + `SDRAM_TRP;
                end
                3'b011: begin
                    if (!inited) begin
                        report_violation("activate before initialisation finished");
                    end
                    if (bank_open[ba]) begin
                        report_violation("activate to a bank that is already open");
                    end
                    bank_open[ba] = 1'b1;
                    open_row[ba] = address;
                    act_cycle[ba] = cycle;
                end
                3'b101, 3'b100: begin
                    n_access++;
                    if (!bank_open[ba]) begin
                        report_violation("read or write to a bank that is not open");
                    end else if (cycle - act_cycle[ba] < `SDRAM_TRCD) begin
                        report_violation("read or write issued before tRCD elapsed");
                    end
                    if (!address[10]) begin
                        report_violation("read or write without auto-precharge");
                    end
                    bank_open[ba] = 1'b0;
                    word = mem.exists(key) ? mem[key] : fill_word(key);
                    if (nwe) begin
                        rd_valid[0] <= 1'b1;
                        rd_data[0]  <= word;
                    end else begin
                        // dqm high masks the byte
                        for (int b = 0; b < NBYTES; b++) begin
                            if (!dqm[b]) begin
                                word[8*b +: 8] = data_in[8*b +: 8];
                            end
                        end
                        mem[key] = word;
                    end
                end
                default: begin
                    report_violation("unknown command on the SDRAM pins");
                end
            endcase
        end
        refresh_count <= n_refresh;
        access_count  <= n_access;
        violations    <= n_violation;
        init_done     <= inited;
        mode_value    <= mode_reg;
    end

endmodule

`default_nettype wire

// ==== test/tb_sdram_controller.sv ====
`default_nettype none

`include "sdram_defs.svh"

module tb_sdram_controller;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int DATA_W = `SDRAM_DATA_WIDTH;
    localparam int NBYTES = DATA_W / 8;
    localparam int ADDR_W = `SDRAM_BANK_BITS + `SDRAM_ROW_WIDTH + `SDRAM_COL_WIDTH;
    localparam int RESET_CYCLES = 10;
    localparam int ACCESS_BOUND = `SDRAM_TRC + `SDRAM_TRCD + `SDRAM_CAS_LATENCY + 20;
    localparam int NUM_ACCESSES = 70;
    localparam int IDLE_CYCLES = 1000;
    localparam int HOLD_CYCLES = 20;
    localparam int INIT_CYCLES = RESET_CYCLES + `SDRAM_INIT_WAIT + 2 * `SDRAM_TRP
                                 + 2 * `SDRAM_TRC + 20;
    localparam int WATCHDOG_CYCLES = INIT_CYCLES + NUM_ACCESSES * ACCESS_BOUND
                                     + IDLE_CYCLES + HOLD_CYCLES;

    logic                          clk = 1'b0;
    logic                          nreset;
    logic [ADDR_W-1:0]             cpu_address;
    logic [DATA_W-1:0]             cpu_data_in;
    logic [DATA_W-1:0]             cpu_data_out;
    logic                          cpu_req;
    logic [NBYTES-1:0]             cpu_nwr;
    logic                          cpu_ack;
    logic                          sdram_clk;
    logic [`SDRAM_ROW_WIDTH-1:0]   sdram_address;
    logic [`SDRAM_BANK_BITS-1:0]   sdram_ba;
    logic                          sdram_ncs;
    logic                          sdram_nras;
    logic                          sdram_ncas;
    logic                          sdram_nwe;
    logic [DATA_W-1:0]             sdram_data_in;
    logic [DATA_W-1:0]             sdram_data_out;
    logic [NBYTES-1:0]             sdram_dqm;
    logic                          init_done;
    logic [`SDRAM_ROW_WIDTH-1:0]   mode_value;
    int                            refresh_count;
    int                            access_count;
    int                            violations;

    logic [DATA_W-1:0] ref_mem [int];
    int                errors = 0;
    int                cycle = 0;

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    sdram_controller i_dut (
        .clk            (clk),
        .nreset         (nreset),
        .cpu_address    (cpu_address),
        .cpu_data_in    (cpu_data_in),
        .cpu_data_out   (cpu_data_out),
        .cpu_req        (cpu_req),
        .cpu_nwr        (cpu_nwr),
        .cpu_ack        (cpu_ack),
        .sdram_clk      (sdram_clk),
        .sdram_address  (sdram_address),
        .sdram_ba       (sdram_ba),
        .sdram_ncs      (sdram_ncs),
        .sdram_nras     (sdram_nras),
        .sdram_ncas     (sdram_ncas),
        .sdram_nwe      (sdram_nwe),
        .sdram_data_in  (sdram_data_in),
        .sdram_data_out (sdram_data_out),
        .sdram_dqm      (sdram_dqm)
    );

    sdram_model i_model (
        .clk           (sdram_clk),
        .address       (sdram_address),
        .ba            (sdram_ba),
        .ncs           (sdram_ncs),
        .nras          (sdram_nras),
        .ncas          (sdram_ncas),
        .nwe           (sdram_nwe),
        .data_in       (sdram_data_out),
        .dqm           (sdram_dqm),
        .data_out      (sdram_data_in),
        .init_done     (init_done),
        .mode_value    (mode_value),
        .refresh_count (refresh_count),
        .access_count  (access_count),
        .violations    (violations)
    );

    task automatic check_value(input string msg, input logic [DATA_W-1:0] got,
                               input logic [DATA_W-1:0] expected);
        if (got !== expected) begin
            errors++;
            $display("Mismatch at %0t: %s, got %h expected %h", $time, msg, got, expected);
        end
    endtask

    // a byte with its nwr bit low takes the new data
    function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old,
                                                      input logic [DATA_W-1:0] wdata,
                                                      input logic [NBYTES-1:0] nwr);
        logic [DATA_W-1:0] result;
        result = old;
        for (int b = 0; b < NBYTES; b++) begin
            if (!nwr[b]) begin
                result[8*b +: 8] = wdata[8*b +: 8];
            end
        end
        return result;
    endfunction

    task automatic raise_request(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                                 input logic [NBYTES-1:0] nwr);
        @(negedge clk);
        cpu_address = addr;
        cpu_data_in = data;
        cpu_nwr     = nwr;
        cpu_req     = 1'b1;
    endtask

    task automatic await_ack();
        while (cpu_ack !== 1'b1) begin
            @(negedge clk);
        end
    endtask

    // called on a falling edge right after the ack was seen
    task automatic drop_request();
        int waited;
        waited = 0;
        cpu_req = 1'b0;
        while (cpu_ack !== 1'b0 && waited < 2) begin
            @(negedge clk);
            waited++;
        end
        if (cpu_ack !== 1'b0) begin
            errors++;
            $display("cpu_ack still high two cycles after cpu_req was released at %0t", $time);
        end
    endtask

    task automatic cpu_access(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                              input logic [NBYTES-1:0] nwr, output logic [DATA_W-1:0] rdata);
        raise_request(addr, data, nwr);
        await_ack();
        rdata = cpu_data_out;
        drop_request();
    endtask

    task automatic write_word(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                              input logic [NBYTES-1:0] nwr);
        logic [DATA_W-1:0] old;
        logic [DATA_W-1:0] unused;
        old = ref_mem.exists(addr) ? ref_mem[addr] : '0;
        cpu_access(addr, data, nwr, unused);
        ref_mem[addr] = merge_bytes(old, data, nwr);
    endtask

    task automatic read_and_compare(input logic [ADDR_W-1:0] addr, input string msg);
        logic [DATA_W-1:0] rdata;
        cpu_access(addr, '0, '1, rdata);
        check_value($sformatf("%s at address %h", msg, addr), rdata, ref_mem[addr]);
    endtask

    task automatic init_sequence();
        wait (init_done === 1'b1);
        @(negedge clk);
        check_value("mode register value", DATA_W'(mode_value), DATA_W'(`SDRAM_MODE_VALUE));
    endtask

    task automatic write_then_read();
        write_word({2'd1, 11'h2a7, 8'h13}, 32'hdeadbeef, '0);
        read_and_compare({2'd1, 11'h2a7, 8'h13}, "full word read back");
    endtask

    task automatic byte_mask_merge();
        logic [ADDR_W-1:0] addr;
        addr = {2'd2, 11'h155, 8'h3c};
        write_word(addr, 32'h11223344, '0);
        write_word(addr, 32'haabbccdd, 4'b1010);
        write_word(addr, 32'h55667788, 4'b0111);
        read_and_compare(addr, "byte masked merge");
    endtask

    task automatic random_traffic();
        logic [ADDR_W-1:0]           addrs [$];
        logic [ADDR_W-1:0]           tmp;
        logic [`SDRAM_BANK_BITS-1:0] bank;
        logic [`SDRAM_ROW_WIDTH-1:0] row;
        logic [`SDRAM_COL_WIDTH-1:0] col;
        int                          j;
        for (int i = 0; i < 30; i++) begin
            // cycle through the banks so every one is hit
            bank = i % (1 << `SDRAM_BANK_BITS);
            row = $urandom;
            col = $urandom;
            addrs.push_back({bank, row, col});
            write_word({bank, row, col}, $urandom, '0);
        end
        for (int i = addrs.size() - 1; i > 0; i--) begin
            j = $urandom_range(i);
            tmp = addrs[i];
            addrs[i] = addrs[j];
            addrs[j] = tmp;
        end
        foreach (addrs[k]) begin
            read_and_compare(addrs[k], "random read back");
        end
    endtask

    task automatic idle_refresh();
        int start_cycle;
        int start_refresh;
        int elapsed;
        int seen;
        @(negedge clk);
        start_cycle = cycle;
        start_refresh = refresh_count;
        repeat (IDLE_CYCLES / 2) @(negedge clk);
        write_word({2'd3, 11'h7ff, 8'hff}, 32'h0badf00d, '0);
        read_and_compare({2'd3, 11'h7ff, 8'hff}, "access during idle stretch");
        repeat (IDLE_CYCLES / 2) @(negedge clk);
        elapsed = cycle - start_cycle;
        seen = refresh_count - start_refresh;
        check_value("refreshes over idle stretch",
                    DATA_W'(seen >= elapsed / `SDRAM_REFRESH_INTERVAL - 1), 1);
    endtask

    task automatic held_request();
        logic [ADDR_W-1:0] addr;
        int                accesses_before;
        addr = {2'd0, 11'h0c3, 8'h81};
        raise_request(addr, 32'hc0ffee11, '0);
        await_ack();
        ref_mem[addr] = 32'hc0ffee11;
        accesses_before = access_count;
        repeat (HOLD_CYCLES) begin
            @(negedge clk);
            check_value("cpu_ack held while cpu_req high", DATA_W'(cpu_ack), 1);
            check_value("no second access while held", access_count, accesses_before);
        end
        drop_request();
        read_and_compare(addr, "read after held write");
    endtask

    initial begin
        void'($urandom(32'ha213cbe7));
        nreset = 1'b0;
        cpu_req = 1'b0;
        cpu_address = '0;
        cpu_data_in = '0;
        cpu_nwr = '1;
        repeat (RESET_CYCLES) @(negedge clk);
        nreset = 1'b1;
        init_sequence();
        write_then_read();
        byte_mask_merge();
        random_traffic();
        idle_refresh();
        held_request();
        repeat (5) @(negedge clk);
        $display("errors: %0d mismatches, %0d protocol violations", errors, violations);
        if (errors == 0 && violations == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: tests did not complete within %0d cycles", WATCHDOG_CYCLES);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sdram_ctrl.f ====
+incdir+include
source/sdram_pkg.sv
source/sdram_timer.sv
source/sdram_sequencer.sv
source/sdram_cmd_reg.sv
source/sdram_read_capture.sv
source/sdram_controller.sv
test/sdram_model.sv
test/tb_sdram_controller.sv
